//--- enoc_pkg.sv
// ----------------------------------------------------------
// Fixed 3x3 mesh, single-flit packets only, no wraparound
// Destinations outside the mesh are not checked
// ----------------------------------------------------------
`default_nettype none

package enoc_pkg;

  // Mesh size
  // ----------------------------------------------------------
  localparam int X_NODES = 3;                  // Columns
  localparam int Y_NODES = 3;                  // Rows
  localparam int NODES   = X_NODES * Y_NODES;  // Router n = y*X_NODES + x

  // Router port numbering
  // ----------------------------------------------------------
  localparam int DEGREE     = 5;
  localparam int PORT_LOCAL = 0;
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST  = 2;
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;
  localparam int PORT_W     = $clog2(DEGREE);  // Port index width

  // Field widths
  localparam int COORD_W   = 2;
  localparam int SEQ_W     = 8;
  localparam int PAYLOAD_W = 16;

  // Input buffering
  // ----------------------------------------------------------
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);      // Pointer width
  localparam int QUEUE_CW    = $clog2(QUEUE_DEPTH + 1);  // Count 0..DEPTH

  // Node location in the mesh
  typedef struct packed {
    logic [COORD_W-1:0] x;  // Column
    logic [COORD_W-1:0] y;  // Row
  } coord_t;

  // One packet is one flit, 32 bits
  typedef struct packed {
    coord_t               dest;     // Routing uses this only
    coord_t               src;
    logic [SEQ_W-1:0]     seq;      // Tag per src/dest pair
    logic [PAYLOAD_W-1:0] payload;
  } packet_t;

  // One bit per router port
  typedef logic [0:DEGREE-1] port_vec_t;

  // Index of one router port
  typedef logic [PORT_W-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- enoc_input_queue.sv
// ----------------------------------------------------------
// Enable depends on fullness only, never on i_data_val
// Pop on an empty queue is ignored
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_input_queue (
  input  wire  logic              i_clk,
  input  wire  logic              i_rst_n,

  // Upstream side, valid/enable
  input  wire  enoc_pkg::packet_t i_data,
  input  wire  logic              i_data_val,
  output logic                    o_en,

  // Head of queue towards the allocator
  input  wire  logic              i_pop,       // Remove head this edge
  output enoc_pkg::packet_t       o_head,
  output logic                    o_head_val
);

  enoc_pkg::packet_t                 mem [0:enoc_pkg::QUEUE_DEPTH-1];  // Packet storage
  logic [enoc_pkg::QUEUE_AW-1:0]     wr_ptr;
  logic [enoc_pkg::QUEUE_AW-1:0]     rd_ptr;
  logic [enoc_pkg::QUEUE_CW-1:0]     count;   // Entries held
  logic                              push;
  logic                              pop;

  assign o_en       = (int'(count) != enoc_pkg::QUEUE_DEPTH);  // Not full
  assign o_head_val = (count != '0);
  assign o_head     = mem[rd_ptr];

  assign push = i_data_val & o_en;    // Handshake
  assign pop  = i_pop & o_head_val;

  // Storage
  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  // Pointers and count
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin  // Wrap at end of buffer
        wr_ptr <= (int'(wr_ptr) == enoc_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == enoc_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                        // Both or neither, count holds
      endcase
    end
  end

endmodule

`default_nettype wire

//--- enoc_route_decode.sv
// ----------------------------------------------------------
// XY order, X resolved first; dest must lie inside the mesh
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_route_decode #(
  parameter int X_LOC = 0,  // Column of this router
  parameter int Y_LOC = 0   // Row of this router
) (
  input  wire  enoc_pkg::packet_t   [0:enoc_pkg::DEGREE-1] i_head,
  input  wire  enoc_pkg::port_vec_t                        i_head_val,
  output enoc_pkg::port_vec_t       [0:enoc_pkg::DEGREE-1] o_req     // One-hot per input
);

  always_comb begin
    for (int i = 0; i < enoc_pkg::DEGREE; i++) begin
      o_req[i] = '0;  // Invalid head asks for nothing
      if (i_head_val[i]) begin
        if (int'(i_head[i].dest.x) > X_LOC) begin
          o_req[i][enoc_pkg::PORT_EAST] = 1'b1;
        end else if (int'(i_head[i].dest.x) < X_LOC) begin
          o_req[i][enoc_pkg::PORT_WEST] = 1'b1;
        end else if (int'(i_head[i].dest.y) > Y_LOC) begin  // Column reached
          o_req[i][enoc_pkg::PORT_NORTH] = 1'b1;
        end else if (int'(i_head[i].dest.y) < Y_LOC) begin
          o_req[i][enoc_pkg::PORT_SOUTH] = 1'b1;
        end else begin
          o_req[i][enoc_pkg::PORT_LOCAL] = 1'b1;            // Arrived
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- enoc_switch_alloc.sv
// ----------------------------------------------------------
// Expects one-hot requests, so one input wins one output max
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_switch_alloc (
  input  wire  logic                                       i_clk,
  input  wire  logic                                       i_rst_n,

  // From the queues and route decode
  input  wire  enoc_pkg::port_vec_t [0:enoc_pkg::DEGREE-1] i_req,       // [input][output]
  input  wire  enoc_pkg::packet_t   [0:enoc_pkg::DEGREE-1] i_head,
  output enoc_pkg::port_vec_t                              o_pop,       // One per input

  // To the output stages
  input  wire  enoc_pkg::port_vec_t                        i_out_ready,
  output enoc_pkg::packet_t         [0:enoc_pkg::DEGREE-1] o_out_data,
  output enoc_pkg::port_vec_t                              o_out_val
);

  enoc_pkg::port_vec_t [0:enoc_pkg::DEGREE-1] grant;  // [output][input]
  enoc_pkg::port_idx_t [0:enoc_pkg::DEGREE-1] win;    // Winning input per output
  enoc_pkg::port_idx_t [0:enoc_pkg::DEGREE-1] prio;   // First input to look at

  // Arbitration
  // ----------------------------------------------------------
  always_comb begin
    int idx;
    o_pop = '0;
    for (int o = 0; o < enoc_pkg::DEGREE; o++) begin
      grant[o] = '0;
      win[o]   = '0;
      // Scan inputs starting at the priority pointer
      for (int k = 0; k < enoc_pkg::DEGREE; k++) begin
        idx = (int'(prio[o]) + k) % enoc_pkg::DEGREE;
        if (i_out_ready[o] && i_req[idx][o] && (grant[o] == '0)) begin
          grant[o][idx] = 1'b1;
          win[o]        = enoc_pkg::port_idx_t'(idx);
        end
      end
      o_pop = o_pop | grant[o];  // Winner leaves its queue
    end
  end

  // Crossbar
  always_comb begin
    for (int o = 0; o < enoc_pkg::DEGREE; o++) begin
      o_out_data[o] = i_head[win[o]];
      o_out_val[o]  = |grant[o];
    end
  end

  // Pointer moves one past the winner, only after a grant
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      prio <= '0;
    end else begin
      for (int o = 0; o < enoc_pkg::DEGREE; o++) begin
        if (|grant[o]) begin
          prio[o] <= (int'(win[o]) == enoc_pkg::DEGREE - 1) ? '0 : win[o] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- enoc_output_stage.sv
// ----------------------------------------------------------
// One-entry slot; o_ready follows i_en the same cycle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_output_stage (
  input  wire  logic              i_clk,
  input  wire  logic              i_rst_n,

  // From the crossbar
  input  wire  enoc_pkg::packet_t i_data,
  input  wire  logic              i_data_val,
  output logic                    o_ready,     // Slot can load this edge

  // Downstream link, valid/enable
  output enoc_pkg::packet_t       o_data,
  output logic                    o_data_val,
  input  wire  logic              i_en
);

  // Empty, or current packet leaves this edge
  assign o_ready = ~o_data_val | i_en;

  // Valid flag
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data_val <= 1'b0;
    end else if (o_ready) begin
      o_data_val <= i_data_val;  // Refill or go empty
    end
  end

  // Packet register, stable while blocked
  always_ff @(posedge i_clk) begin
    if (o_ready && i_data_val) o_data <= i_data;
  end

endmodule

`default_nettype wire

//--- enoc_router.sv
// ----------------------------------------------------------
// Two cycles per hop when uncontended: queue, then out stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_router #(
  parameter int X_LOC = 0,  // Column in the mesh
  parameter int Y_LOC = 0   // Row in the mesh
) (
  input  wire  logic                                       i_clk,
  input  wire  logic                                       i_rst_n,

  // Input side, one link per port
  input  wire  enoc_pkg::packet_t   [0:enoc_pkg::DEGREE-1] i_data,
  input  wire  enoc_pkg::port_vec_t                        i_data_val,
  output enoc_pkg::port_vec_t                              o_en,

  // Output side, one link per port
  output enoc_pkg::packet_t         [0:enoc_pkg::DEGREE-1] o_data,
  output enoc_pkg::port_vec_t                              o_data_val,
  input  wire  enoc_pkg::port_vec_t                        i_en
);

  enoc_pkg::packet_t   [0:enoc_pkg::DEGREE-1] head;       // Queue heads
  enoc_pkg::port_vec_t                        head_val;
  enoc_pkg::port_vec_t [0:enoc_pkg::DEGREE-1] req;        // [input][output]
  enoc_pkg::port_vec_t                        pop;
  enoc_pkg::packet_t   [0:enoc_pkg::DEGREE-1] xbar_data;  // Crossbar to stages
  enoc_pkg::port_vec_t                        xbar_val;
  enoc_pkg::port_vec_t                        out_ready;

  // Input queues
  // ----------------------------------------------------------
  for (genvar p = 0; p < enoc_pkg::DEGREE; p++) begin : g_queue
    enoc_input_queue u_queue (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .i_pop      (pop[p]),
      .o_head     (head[p]),
      .o_head_val (head_val[p])
    );
  end

  // Route decode of every head
  enoc_route_decode #(
    .X_LOC (X_LOC),
    .Y_LOC (Y_LOC)
  ) u_route (
    .i_head     (head),
    .i_head_val (head_val),
    .o_req      (req)
  );

  // Arbitration and crossbar
  enoc_switch_alloc u_alloc (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (req),
    .i_head      (head),
    .o_pop       (pop),
    .i_out_ready (out_ready),
    .o_out_data  (xbar_data),
    .o_out_val   (xbar_val)
  );

  // Output stages
  // ----------------------------------------------------------
  for (genvar p = 0; p < enoc_pkg::DEGREE; p++) begin : g_out
    enoc_output_stage u_out (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_data     (xbar_data[p]),
      .i_data_val (xbar_val[p]),
      .o_ready    (out_ready[p]),
      .o_data     (o_data[p]),
      .o_data_val (o_data_val[p]),
      .i_en       (i_en[p])
    );
  end

endmodule

`default_nettype wire

//--- enoc_network.sv
// ----------------------------------------------------------
// Node n sits at x = n % X_NODES, y = n / X_NODES
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module enoc_network (
  input  wire  logic                                    i_clk,
  input  wire  logic                                    i_rst_n,

  // Nodes to network
  input  wire  enoc_pkg::packet_t [0:enoc_pkg::NODES-1] i_data,
  input  wire  logic              [0:enoc_pkg::NODES-1] i_data_val,
  output logic                    [0:enoc_pkg::NODES-1] o_en,

  // Network to nodes
  output enoc_pkg::packet_t       [0:enoc_pkg::NODES-1] o_data,
  output logic                    [0:enoc_pkg::NODES-1] o_data_val,
  input  wire  logic              [0:enoc_pkg::NODES-1] i_en
);

  // Router side of every link, [router][port]
  enoc_pkg::packet_t   [0:enoc_pkg::NODES-1][0:enoc_pkg::DEGREE-1] l_din;
  enoc_pkg::port_vec_t [0:enoc_pkg::NODES-1]                       l_din_val;
  enoc_pkg::port_vec_t [0:enoc_pkg::NODES-1]                       l_oen;      // Queue enables
  enoc_pkg::packet_t   [0:enoc_pkg::NODES-1][0:enoc_pkg::DEGREE-1] l_dout;
  enoc_pkg::port_vec_t [0:enoc_pkg::NODES-1]                       l_dout_val;
  enoc_pkg::port_vec_t [0:enoc_pkg::NODES-1]                       l_ien;      // Stage enables

  for (genvar y = 0; y < enoc_pkg::Y_NODES; y++) begin : g_y
    for (genvar x = 0; x < enoc_pkg::X_NODES; x++) begin : g_x
      localparam int N = y * enoc_pkg::X_NODES + x;  // Router number

      // Local node
      assign l_din[N][enoc_pkg::PORT_LOCAL]     = i_data[N];
      assign l_din_val[N][enoc_pkg::PORT_LOCAL] = i_data_val[N];
      assign l_ien[N][enoc_pkg::PORT_LOCAL]     = i_en[N];
      assign o_en[N]       = l_oen[N][enoc_pkg::PORT_LOCAL];
      assign o_data[N]     = l_dout[N][enoc_pkg::PORT_LOCAL];
      assign o_data_val[N] = l_dout_val[N][enoc_pkg::PORT_LOCAL];

      // Neighbour links, edges tied off
      // ----------------------------------------------------------
      if (y < enoc_pkg::Y_NODES - 1) begin : g_north  // From south side of router above
        assign l_din[N][enoc_pkg::PORT_NORTH]     = l_dout[N+enoc_pkg::X_NODES][enoc_pkg::PORT_SOUTH];
        assign l_din_val[N][enoc_pkg::PORT_NORTH] =
          l_dout_val[N+enoc_pkg::X_NODES][enoc_pkg::PORT_SOUTH];
        assign l_ien[N][enoc_pkg::PORT_NORTH]     = l_oen[N+enoc_pkg::X_NODES][enoc_pkg::PORT_SOUTH];
      end else begin : g_north_edge
        assign l_din[N][enoc_pkg::PORT_NORTH]     = '0;
        assign l_din_val[N][enoc_pkg::PORT_NORTH] = 1'b0;
        assign l_ien[N][enoc_pkg::PORT_NORTH]     = 1'b0;
      end

      if (x < enoc_pkg::X_NODES - 1) begin : g_east   // From west side of router to the right
        assign l_din[N][enoc_pkg::PORT_EAST]     = l_dout[N+1][enoc_pkg::PORT_WEST];
        assign l_din_val[N][enoc_pkg::PORT_EAST] = l_dout_val[N+1][enoc_pkg::PORT_WEST];
        assign l_ien[N][enoc_pkg::PORT_EAST]     = l_oen[N+1][enoc_pkg::PORT_WEST];
      end else begin : g_east_edge
        assign l_din[N][enoc_pkg::PORT_EAST]     = '0;
        assign l_din_val[N][enoc_pkg::PORT_EAST] = 1'b0;
        assign l_ien[N][enoc_pkg::PORT_EAST]     = 1'b0;
      end

      if (y > 0) begin : g_south
        assign l_din[N][enoc_pkg::PORT_SOUTH]     = l_dout[N-enoc_pkg::X_NODES][enoc_pkg::PORT_NORTH];
        assign l_din_val[N][enoc_pkg::PORT_SOUTH] =
          l_dout_val[N-enoc_pkg::X_NODES][enoc_pkg::PORT_NORTH];
        assign l_ien[N][enoc_pkg::PORT_SOUTH]     = l_oen[N-enoc_pkg::X_NODES][enoc_pkg::PORT_NORTH];
      end else begin : g_south_edge
        assign l_din[N][enoc_pkg::PORT_SOUTH]     = '0;
        assign l_din_val[N][enoc_pkg::PORT_SOUTH] = 1'b0;
        assign l_ien[N][enoc_pkg::PORT_SOUTH]     = 1'b0;
      end

      if (x > 0) begin : g_west
        assign l_din[N][enoc_pkg::PORT_WEST]     = l_dout[N-1][enoc_pkg::PORT_EAST];
        assign l_din_val[N][enoc_pkg::PORT_WEST] = l_dout_val[N-1][enoc_pkg::PORT_EAST];
        assign l_ien[N][enoc_pkg::PORT_WEST]     = l_oen[N-1][enoc_pkg::PORT_EAST];
      end else begin : g_west_edge
        assign l_din[N][enoc_pkg::PORT_WEST]     = '0;
        assign l_din_val[N][enoc_pkg::PORT_WEST] = 1'b0;
        assign l_ien[N][enoc_pkg::PORT_WEST]     = 1'b0;
      end

      enoc_router #(
        .X_LOC (x),
        .Y_LOC (y)
      ) u_router (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_data     (l_din[N]),
        .i_data_val (l_din_val[N]),
        .o_en       (l_oen[N]),
        .o_data     (l_dout[N]),
        .o_data_val (l_dout_val[N]),
        .i_en       (l_ien[N])
      );
    end
  end

endmodule

`default_nettype wire

//--- tb_enoc_network.sv
// ----------------------------------------------------------
// Checks at the falling edge; sources obey valid/enable hold
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_enoc_network;

  localparam logic [0:enoc_pkg::NODES-1] ALL_NODES = '1;

  logic                                    i_clk;
  logic                                    i_rst_n;
  enoc_pkg::packet_t [0:enoc_pkg::NODES-1] i_data;
  logic              [0:enoc_pkg::NODES-1] i_data_val;
  logic              [0:enoc_pkg::NODES-1] o_en;
  enoc_pkg::packet_t [0:enoc_pkg::NODES-1] o_data;
  logic              [0:enoc_pkg::NODES-1] o_data_val;
  logic              [0:enoc_pkg::NODES-1] i_en;

  // Traffic and scoreboard state
  // ----------------------------------------------------------
  enoc_pkg::packet_t          tx_q     [enoc_pkg::NODES][$];  // Per source, all ever queued
  enoc_pkg::packet_t          exp_q    [enoc_pkg::NODES][$];  // Per destination
  int                         tx_ptr   [enoc_pkg::NODES];     // Next packet to present
  logic [enoc_pkg::SEQ_W-1:0] seq_cnt  [enoc_pkg::NODES][enoc_pkg::NODES];
  enoc_pkg::packet_t          hold_pkt [enoc_pkg::NODES];
  logic [0:enoc_pkg::NODES-1] tx_acc;     // Source handshake on next edge
  logic [0:enoc_pkg::NODES-1] hold_val;   // Sink refused last cycle
  bit                         rand_gaps;  // Idle cycles at sources
  bit                         rand_en;    // Random sink enables
  int                         blocked;    // Sink held off, -1 for none
  int                         mon_errors;
  int                         main_errors;
  int                         delivered;
  string                      test_name;
  event                       sampled;    // Falling-edge checks done

  enoc_network i_dut (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  initial begin : clock
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;  // 40 ns period
  end

  function automatic enoc_pkg::coord_t node_coord(input int n);
    enoc_pkg::coord_t c;
    int               x;
    int               y;
    x   = n % enoc_pkg::X_NODES;
    y   = n / enoc_pkg::X_NODES;
    c.x = x[enoc_pkg::COORD_W-1:0];
    c.y = y[enoc_pkg::COORD_W-1:0];
    return c;
  endfunction

  function automatic int node_index(input enoc_pkg::coord_t c);
    return int'(c.y) * enoc_pkg::X_NODES + int'(c.x);
  endfunction

  function automatic void print_mismatch(input string what, input logic [31:0] exp_v,
                                         input logic [31:0] act_v);
    $display("Error %s, %s: expected %h, actual %h", test_name, what, exp_v, act_v);
  endfunction

  // Oldest outstanding packet from the same source must match
  task automatic check_arrival(input int n, input enoc_pkg::packet_t pkt);
    int found;
    found = -1;
    assert (node_index(pkt.dest) == n) else begin
      print_mismatch("dest node", 32'(n), 32'(node_index(pkt.dest)));
      mon_errors++;
    end
    for (int i = 0; i < exp_q[n].size(); i++) begin
      if (found < 0 && exp_q[n][i].src == pkt.src) found = i;
    end
    assert (found >= 0) else begin
      $display("Packet %h arrived at node %0d in %s but none was outstanding",
               pkt, n, test_name);
      mon_errors++;
    end
    if (found >= 0) begin
      assert (pkt == exp_q[n][found]) else begin
        print_mismatch($sformatf("packet at node %0d", n), exp_q[n][found], pkt);
        mon_errors++;
      end
      exp_q[n].delete(found);
      delivered++;
    end
  endtask

  // Sources, sinks and monitor
  // ----------------------------------------------------------
  initial begin : traffic
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    tx_acc     = '0;
    hold_val   = '0;
    mon_errors = 0;
    delivered  = 0;
    for (int n = 0; n < enoc_pkg::NODES; n++) tx_ptr[n] = 0;
    forever begin
      @(posedge i_clk);
      for (int n = 0; n < enoc_pkg::NODES; n++) begin
        if (tx_acc[n]) begin  // Packet taken on this edge
          exp_q[node_index(i_data[n].dest)].push_back(i_data[n]);
          tx_ptr[n]++;
        end
        if (!i_data_val[n] || tx_acc[n]) begin  // Free to change
          if (tx_ptr[n] < tx_q[n].size() && (!rand_gaps || $urandom_range(3) != 0)) begin
            i_data[n]     <= tx_q[n][tx_ptr[n]];
            i_data_val[n] <= 1'b1;
          end else begin
            i_data_val[n] <= 1'b0;
          end
        end
        if (n == blocked) begin
          i_en[n] <= 1'b0;
        end else if (rand_en) begin
          i_en[n] <= ($urandom_range(3) != 0);  // High three cycles in four
        end else begin
          i_en[n] <= 1'b1;
        end
      end
      @(negedge i_clk);
      for (int n = 0; n < enoc_pkg::NODES; n++) begin
        tx_acc[n] = i_data_val[n] & o_en[n];
        if (hold_val[n]) begin  // Refused output must stay put
          assert (o_data_val[n] && o_data[n] == hold_pkt[n]) else begin
            print_mismatch($sformatf("held output at node %0d", n),
                           hold_pkt[n], o_data_val[n] ? o_data[n] : 32'h0);
            mon_errors++;
          end
        end
        hold_val[n] = o_data_val[n] & ~i_en[n];
        hold_pkt[n] = o_data[n];
        if (o_data_val[n] && i_en[n]) check_arrival(n, o_data[n]);
      end
      -> sampled;
    end
  end

  task automatic enqueue(input int src, input int dst);
    enoc_pkg::packet_t pkt;
    logic [31:0]       r;
    r           = $urandom;
    pkt.dest    = node_coord(dst);
    pkt.src     = node_coord(src);
    pkt.seq     = seq_cnt[src][dst];
    pkt.payload = r[enoc_pkg::PAYLOAD_W-1:0];
    seq_cnt[src][dst]++;
    tx_q[src].push_back(pkt);
  endtask

  function automatic bit network_idle();
    bit idle;
    idle = (i_data_val == '0);
    for (int n = 0; n < enoc_pkg::NODES; n++) begin
      if (tx_ptr[n] != tx_q[n].size() || exp_q[n].size() != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (!network_idle() && cycles < limit) begin
      @(sampled);
      cycles++;
    end
    assert (network_idle()) else begin
      $display("Timeout in %s, packets still in flight after %0d cycles", test_name, limit);
      main_errors++;
    end
  endtask

  // Test sequence
  // ----------------------------------------------------------
  initial begin : main
    int cycles;
    void'($urandom(28));
    i_rst_n     = 1'b0;
    rand_gaps   = 1'b0;
    rand_en     = 1'b0;
    blocked     = -1;
    main_errors = 0;
    test_name   = "reset_idle";
    for (int s = 0; s < enoc_pkg::NODES; s++) begin
      for (int d = 0; d < enoc_pkg::NODES; d++) seq_cnt[s][d] = '0;
    end
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(sampled);

    assert (o_en == ALL_NODES) else begin
      print_mismatch("o_en", 32'(ALL_NODES), 32'(o_en));
      main_errors++;
    end
    for (int i = 0; i < 10; i++) begin  // Quiet network stays quiet
      assert (o_data_val == '0) else begin
        print_mismatch("o_data_val", 32'h0, 32'(o_data_val));
        main_errors++;
      end
      @(sampled);
    end

    test_name = "single_packets";
    for (int s = 0; s < enoc_pkg::NODES; s++) begin
      for (int d = 0; d < enoc_pkg::NODES; d++) begin
        enqueue(s, d);
        wait_drain(100);
      end
    end

    test_name = "in_order";
    for (int i = 0; i < 8; i++) enqueue(0, 8);
    wait_drain(200);

    test_name = "back_pressure";
    blocked   = 8;  // Far corner refuses everything
    for (int i = 0; i < 40; i++) enqueue(0, 8);
    cycles = 0;
    while (o_en[0] && cycles < 500) begin
      @(sampled);
      cycles++;
    end
    assert (!o_en[0]) else begin
      print_mismatch("o_en at node 0", 32'h0, 32'(o_en[0]));
      main_errors++;
    end
    assert (o_data_val[8]) else begin
      print_mismatch("o_data_val at node 8", 32'h1, 32'(o_data_val[8]));
      main_errors++;
    end
    blocked = -1;
    wait_drain(500);

    test_name = "random_traffic";
    rand_gaps = 1'b1;
    rand_en   = 1'b1;
    for (int s = 0; s < enoc_pkg::NODES; s++) begin
      for (int i = 0; i < 24; i++) enqueue(s, $urandom_range(enoc_pkg::NODES - 1));
    end
    wait_drain(4000);

    $display("Summary: %0d monitor errors, %0d sequence errors, %0d packets delivered",
             mon_errors, main_errors, delivered);
    if (mon_errors == 0 && main_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- enoc_network.f
enoc_pkg.sv
enoc_input_queue.sv
enoc_route_decode.sv
enoc_switch_alloc.sv
enoc_output_stage.sv
enoc_router.sv
enoc_network.sv
tb_enoc_network.sv

//--- Makefile
TOP := tb_enoc_network

all: run

build:
	verilator --binary --timing --assert -f enoc_network.f --top-module $(TOP) -Mdir obj_dir

run: build
	obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f enoc_network.f --top-module enoc_network

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
